//--- bench/matmul_assertions.sv
module matmul_assertions
  import matmul_pkg::*;
(
  input logic     clk,
  input logic     resetn,
  input logic     start_reg,
  input logic     done_reg,
  input logic     busy,
  input logic     start_mat_mul,
  input logic     done_mat_mul,
  input ram_req_t req_a,
  input ram_req_t req_b,
  input ram_req_t req_c,
  input ram_req_t engine_req_c
);

  // failures seen so far, read by the testbench at the end
  int unsigned assert_errors = 0;

  // start accepted in idle, done_reg follows after the fixed engine run
  done_latency: assert property (@(posedge clk) disable iff (!resetn)
    (start_reg && !busy && !done_reg) |=> !done_reg [*20] ##1 done_reg)
  else begin
    $error("done_reg did not rise 20 cycles after the accepted start");
    assert_errors++;
  end

  // nothing moves in idle without a start
  idle_quiet: assert property (@(posedge clk) disable iff (!resetn)
    (!busy && !done_reg && !start_reg) |=> (!busy && !done_reg))
  else begin
    $error("status left idle without a start pulse");
    assert_errors++;
  end

  done_pulse: assert property (@(posedge clk) disable iff (!resetn)
    done_mat_mul |=> !done_mat_mul)
  else begin
    $error("done_mat_mul held longer than one cycle");
    assert_errors++;
  end

  // the engine never writes A or B, so any strobe there while busy is a host leak
  no_host_write: assert property (@(posedge clk) disable iff (!resetn)
    busy |-> (!req_a.we && !req_b.we && (!req_c.we || engine_req_c.we)))
  else begin
    $error("memory write strobe active while busy without the engine");
    assert_errors++;
  end

  reset_status: assert property (@(posedge clk)
    $rose(resetn) |-> (!done_reg && !busy && !start_mat_mul && !done_mat_mul))
  else begin
    $error("status outputs not low right after reset");
    assert_errors++;
  end

endmodule

bind matmul_top matmul_assertions u_assertions (
  .clk           (clk),
  .resetn        (resetn),
  .start_reg     (start_reg),
  .done_reg      (done_reg),
  .busy          (busy),
  .start_mat_mul (start_mat_mul),
  .done_mat_mul  (done_mat_mul),
  .req_a         (req_a),
  .req_b         (req_b),
  .req_c         (req_c),
  .engine_req_c  (engine_req_c)
);

//--- bench/tb_matmul.sv
module tb_matmul
  import matmul_pkg::*;
();

  logic      clk;
  logic      resetn;
  logic      start_reg;
  logic      clear_done_reg;
  host_req_t host_req;
  logic      done_reg;
  logic      busy;
  mat_row_t  c_rdata;

  // reference copies of the matrices indexed [row][col]
  logic [data_width-1:0] a_m   [mat_size][mat_size];
  logic [data_width-1:0] b_m   [mat_size][mat_size];
  logic [data_width-1:0] c_exp [mat_size][mat_size];

  logic [31:0] rng_state;
  int          errors;
  int          test_errors;
  int          tests_run;

  matmul_top UUT (
    .clk            (clk),
    .resetn         (resetn),
    .start_reg      (start_reg),
    .clear_done_reg (clear_done_reg),
    .host_req       (host_req),
    .done_reg       (done_reg),
    .busy           (busy),
    .c_rdata        (c_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic fill_random();
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        rng_state = xorshift32(rng_state);
        a_m[i][j] = rng_state[7:0];
        b_m[i][j] = rng_state[15:8];
      end
    end
  endtask

  // C[i][j] is the sum over k of A[i][k]*B[k][j] modulo 256
  task automatic compute_reference();
    int sum;
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        sum = 0;
        for (int k = 0; k < mat_size; k++) begin
          sum += int'(a_m[i][k]) * int'(b_m[k][j]);
        end
        c_exp[i][j] = data_width'(sum % 256);
      end
    end
  endtask

  task automatic write_row(input mat_sel_e sel, input int addr, input mat_row_t data);
    host_req.we    = 1'b1;
    host_req.sel   = sel;
    host_req.waddr = addr_width'(addr);
    host_req.wdata = data;
    next_cycle();
    host_req.we    = 1'b0;
  endtask

  // A goes in by columns and B by rows
  task automatic load_matrices();
    mat_row_t word;
    for (int k = 0; k < mat_size; k++) begin
      for (int i = 0; i < mat_size; i++) begin
        word[i] = a_m[i][k];
      end
      write_row(mat_a, k, word);
    end
    for (int k = 0; k < mat_size; k++) begin
      for (int j = 0; j < mat_size; j++) begin
        word[j] = b_m[k][j];
      end
      write_row(mat_b, k, word);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("%0d tests, %0d check errors, %0d assertion failures",
             tests_run, errors + test_errors, UUT.u_assertions.assert_errors);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic start_run();
    start_reg = 1'b1;
    next_cycle();
    start_reg = 1'b0;
  endtask

  task automatic wait_for_done();
    int n;
    n = 0;
    while (!done_reg && n < 100) begin
      next_cycle();
      n++;
    end
    if (!done_reg) begin
      abort_run("timeout while waiting for done_reg to rise");
    end
  endtask

  task automatic wait_for_busy();
    int n;
    n = 0;
    while (!busy && n < 20) begin
      next_cycle();
      n++;
    end
    if (!busy) begin
      abort_run("timeout while waiting for busy after a start pulse");
    end
  endtask

  task automatic clear_done();
    int n;
    clear_done_reg = 1'b1;
    next_cycle();
    clear_done_reg = 1'b0;
    n = 0;
    while (done_reg && n < 20) begin
      next_cycle();
      n++;
    end
    if (done_reg) begin
      abort_run("timeout while waiting for done_reg to clear");
    end
  endtask

  task automatic run_matmul();
    start_run();
    wait_for_done();
  endtask

  // read every C row back and compare with c_exp
  task automatic check_c();
    mat_row_t row;
    for (int i = 0; i < mat_size; i++) begin
      host_req.c_raddr = addr_width'(i);
      next_cycle();
      row = c_rdata;
      for (int j = 0; j < mat_size; j++) begin
        if (row[j] !== c_exp[i][j]) begin
          $display("Fail at time %0t: C[%0d][%0d] is %02h, expected %02h",
                   $time, i, j, row[j], c_exp[i][j]);
          test_errors++;
        end
      end
    end
  endtask

  task automatic report_test(input int num, input string name);
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d mismatches", num, name, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    resetn         = 1'b0;
    start_reg      = 1'b0;
    clear_done_reg = 1'b0;
    host_req       = '0;
    rng_state      = 32'd51;
    errors         = 0;
    test_errors    = 0;
    tests_run      = 0;
    repeat (5) @(posedge clk);
    #1;
    resetn = 1'b1;

    for (int n = 0; n < 4; n++) begin
      if (busy || done_reg) begin
        $display("Fail at time %0t: busy %b done_reg %b in idle", $time, busy, done_reg);
        test_errors++;
      end
      next_cycle();
    end
    report_test(1, "reset status");

    // identity A makes C equal to B
    fill_random();
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        a_m[i][j]   = (i == j) ? 8'd1 : 8'd0;
        c_exp[i][j] = b_m[i][j];
      end
    end
    load_matrices();
    run_matmul();
    check_c();
    clear_done();
    report_test(2, "identity A");

    // row 0 of A and column 0 of B all 0xff gives the largest sum
    fill_random();
    for (int k = 0; k < mat_size; k++) begin
      a_m[0][k] = 8'hff;
      b_m[k][0] = 8'hff;
    end
    compute_reference();
    load_matrices();
    run_matmul();
    check_c();
    clear_done();
    report_test(3, "random with overflow");

    // host write into A while busy and two reruns on the stored matrices
    start_run();
    wait_for_busy();
    rng_state = xorshift32(rng_state);
    write_row(mat_a, 0, {rng_state, ~rng_state});
    wait_for_done();
    check_c();
    clear_done();
    run_matmul();
    check_c();
    clear_done();
    report_test(4, "write dropped while busy");

    fill_random();
    compute_reference();
    load_matrices();
    run_matmul();
    // start in the done state must be ignored
    start_run();
    for (int n = 0; n < 3; n++) begin
      if (!done_reg || busy) begin
        $display("Fail at time %0t: done_reg %b busy %b after start in done",
                 $time, done_reg, busy);
        test_errors++;
      end
      next_cycle();
    end
    check_c();
    clear_done();
    fill_random();
    compute_reference();
    load_matrices();
    run_matmul();
    check_c();
    clear_done();
    report_test(5, "start ignored in done");

    $display("%0d tests, %0d check errors, %0d assertion failures",
             tests_run, errors, UUT.u_assertions.assert_errors);
    if (errors == 0 && UUT.u_assertions.assert_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- common/matmul_pkg.sv
package matmul_pkg;

  // matrix geometry
  localparam int mat_size   = 8;
  localparam int data_width = 8;
  localparam int addr_width = 3;

  // a full sum of eight 16-bit products fits without overflow
  localparam int acc_width  = 19;

  // one matrix row or column, byte i in element i
  typedef logic [mat_size-1:0][data_width-1:0] mat_row_t;

  // host matrix select
  typedef enum logic {
    mat_a = 1'b0,
    mat_b = 1'b1
  } mat_sel_e;

  // request into one row memory
  typedef struct packed {
    logic                  we;
    logic [addr_width-1:0] addr;
    mat_row_t              wdata;
  } ram_req_t;

  // host register port
  typedef struct packed {
    logic                  we;
    mat_sel_e              sel;
    logic [addr_width-1:0] waddr;
    mat_row_t              wdata;
    // C readback address, data returns one cycle later
    logic [addr_width-1:0] c_raddr;
  } host_req_t;

endpackage

//--- filelist.f
common/matmul_pkg.sv
verilog/row_ram.sv
verilog/matmul_control.sv
matmul/mac_array.sv
matmul/matmul_engine.sv
verilog/matmul_top.sv
bench/matmul_assertions.sv
bench/tb_matmul.sv

//--- matmul/mac_array.sv
module mac_array
  import matmul_pkg::*;
(
  input  logic                  clk,
  input  logic                  clear,
  input  logic                  acc_en,
  input  mat_row_t              a_col,
  input  mat_row_t              b_row,
  input  logic [addr_width-1:0] rd_row,
  output mat_row_t              c_row
);

  // acc[i][j] builds C[i][j]
  logic [acc_width-1:0] acc [mat_size][mat_size];

  for (genvar gi = 0; gi < mat_size; gi++) begin : g_row
    for (genvar gj = 0; gj < mat_size; gj++) begin : g_col
      logic [2*data_width-1:0] prod;

      // outer product term A[i][k] * B[k][j]
      assign prod = a_col[gi] * b_row[gj];

      always_ff @(posedge clk) begin
        if (clear) begin
          acc[gi][gj] <= '0;
        end else if (acc_en) begin
          acc[gi][gj] <= acc[gi][gj] + acc_width'(prod);
        end
      end
    end
  end

  // readout keeps the low byte, i.e. the sum modulo 256
  always_comb begin
    for (int j = 0; j < mat_size; j++) begin
      c_row[j] = acc[rd_row][j][data_width-1:0];
    end
  end

endmodule

//--- matmul/matmul_engine.sv
module matmul_engine
  import matmul_pkg::*;
(
  input  logic     clk,
  input  logic     resetn,
  input  logic     start_mat_mul,
  input  mat_row_t a_rdata,
  input  mat_row_t b_rdata,
  output ram_req_t req_a,
  output ram_req_t req_b,
  output ram_req_t req_c,
  output logic     done_mat_mul
);

  typedef enum logic [2:0] {
    ph_idle,
    ph_read,
    ph_drain,
    ph_write,
    ph_done
  } phase_e;

  phase_e                phase;
  logic [addr_width-1:0] cnt;
  logic                  rd_valid;
  logic                  acc_clear;
  logic                  acc_en;
  mat_row_t              c_row;

  // the clear happens in the cycle start is first seen
  assign acc_clear = (phase == ph_idle) && start_mat_mul;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase <= ph_idle;
      cnt   <= '0;
    end else begin
      case (phase)
        ph_idle: begin
          cnt <= '0;
          if (start_mat_mul) begin
            phase <= ph_read;
          end
        end
        ph_read: begin
          cnt <= cnt + 1'b1;
          if (cnt == addr_width'(mat_size - 1)) begin
            phase <= ph_drain;
          end
        end
        // last row is still coming out of the memories
        ph_drain: begin
          cnt   <= '0;
          phase <= ph_write;
        end
        ph_write: begin
          cnt <= cnt + 1'b1;
          if (cnt == addr_width'(mat_size - 1)) begin
            phase <= ph_done;
          end
        end
        ph_done: begin
          cnt   <= '0;
          phase <= ph_idle;
        end
        default: phase <= ph_idle;
      endcase
    end
  end

  // read data lands one cycle after the address, accumulate then
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= (phase == ph_read);
    end
  end

  assign acc_en = rd_valid;

  // A column k and B row k share the address
  always_comb begin
    req_a.we    = 1'b0;
    req_a.addr  = cnt;
    req_a.wdata = '0;
    req_b.we    = 1'b0;
    req_b.addr  = cnt;
    req_b.wdata = '0;
  end

  // C rows go out in order during the write phase
  always_comb begin
    req_c.we    = (phase == ph_write);
    req_c.addr  = cnt;
    req_c.wdata = c_row;
  end

  assign done_mat_mul = (phase == ph_done);

  mac_array u_mac_array (
    .clk    (clk),
    .clear  (acc_clear),
    .acc_en (acc_en),
    .a_col  (a_rdata),
    .b_row  (b_rdata),
    .rd_row (cnt),
    .c_row  (c_row)
  );

endmodule

//--- verilog/matmul_control.sv
module matmul_control
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  logic      start_reg,
  input  logic      clear_done_reg,
  input  host_req_t host_req,
  input  logic      done_mat_mul,
  input  ram_req_t  engine_req_a,
  input  ram_req_t  engine_req_b,
  input  ram_req_t  engine_req_c,
  output logic      start_mat_mul,
  output logic      done_reg,
  output logic      busy,
  output ram_req_t  req_a,
  output ram_req_t  req_b,
  output ram_req_t  req_c
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_run,
    st_done
  } run_state_e;

  run_state_e state;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state         <= st_idle;
      start_mat_mul <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          start_mat_mul <= 1'b0;
          if (start_reg) begin
            state <= st_start;
          end
        end
        st_start: begin
          start_mat_mul <= 1'b1;
          state         <= st_run;
        end
        st_run: begin
          // engine pulses done once, drop the start level at the same edge
          if (done_mat_mul) begin
            start_mat_mul <= 1'b0;
            state         <= st_done;
          end
        end
        st_done: begin
          if (clear_done_reg) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign busy     = (state == st_start) || (state == st_run);
  assign done_reg = (state == st_done);

  // memory ownership: engine while busy, host otherwise
  always_comb begin
    if (busy) begin
      req_a = engine_req_a;
      req_b = engine_req_b;
      req_c = engine_req_c;
    end else begin
      req_a.we    = host_req.we && (host_req.sel == mat_a);
      req_a.addr  = host_req.waddr;
      req_a.wdata = host_req.wdata;
      req_b.we    = host_req.we && (host_req.sel == mat_b);
      req_b.addr  = host_req.waddr;
      req_b.wdata = host_req.wdata;
      // host only reads C
      req_c.we    = 1'b0;
      req_c.addr  = host_req.c_raddr;
      req_c.wdata = '0;
    end
  end

endmodule

//--- verilog/matmul_top.sv
module matmul_top
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  logic      start_reg,
  input  logic      clear_done_reg,
  input  host_req_t host_req,
  output logic      done_reg,
  output logic      busy,
  output mat_row_t  c_rdata
);

  // control to engine
  logic start_mat_mul;
  logic done_mat_mul;

  // engine side requests
  ram_req_t engine_req_a;
  ram_req_t engine_req_b;
  ram_req_t engine_req_c;

  // muxed requests into the memories
  ram_req_t req_a;
  ram_req_t req_b;
  ram_req_t req_c;

  // A and B read data into the engine
  mat_row_t a_rdata;
  mat_row_t b_rdata;

  matmul_control u_control (
    .clk            (clk),
    .resetn         (resetn),
    .start_reg      (start_reg),
    .clear_done_reg (clear_done_reg),
    .host_req       (host_req),
    .done_mat_mul   (done_mat_mul),
    .engine_req_a   (engine_req_a),
    .engine_req_b   (engine_req_b),
    .engine_req_c   (engine_req_c),
    .start_mat_mul  (start_mat_mul),
    .done_reg       (done_reg),
    .busy           (busy),
    .req_a          (req_a),
    .req_b          (req_b),
    .req_c          (req_c)
  );

  matmul_engine u_engine (
    .clk           (clk),
    .resetn        (resetn),
    .start_mat_mul (start_mat_mul),
    .a_rdata       (a_rdata),
    .b_rdata       (b_rdata),
    .req_a         (engine_req_a),
    .req_b         (engine_req_b),
    .req_c         (engine_req_c),
    .done_mat_mul  (done_mat_mul)
  );

  // A holds columns, word k is column k
  row_ram ram_a (
    .clk   (clk),
    .req   (req_a),
    .rdata (a_rdata)
  );

  // B holds rows, word k is row k
  row_ram ram_b (
    .clk   (clk),
    .req   (req_b),
    .rdata (b_rdata)
  );

  // C result rows, read back by the host when idle or done
  row_ram ram_c (
    .clk   (clk),
    .req   (req_c),
    .rdata (c_rdata)
  );

endmodule

//--- verilog/row_ram.sv
module row_ram
  import matmul_pkg::*;
(
  input  logic     clk,
  input  ram_req_t req,
  output mat_row_t rdata
);

  // one full row per address
  mat_row_t mem [mat_size];

  // whole-row write, no byte masks
  always_ff @(posedge clk) begin
    if (req.we) begin
      mem[req.addr] <= req.wdata;
    end
  end

  // registered read, returns the old row on a same-cycle write
  always_ff @(posedge clk) begin
    rdata <= mem[req.addr];
  end

endmodule
